// File: src/lane_cfg.svh
// ----------------------------------------------------------
// Build-time sizes for one graph lane
// Included by the package, the RTL and the testbench
// Engine count, field widths and wait limits live here
// ----------------------------------------------------------
`ifndef LANE_CFG_SVH
`define LANE_CFG_SVH

// Number of chained engines in the lane
`define LANE_NUM_ENGINES 4

// Packet key and value widths
`define LANE_KEY_W 16
`define LANE_DATA_W 32

// Wishbone word address and byte select widths
`define LANE_ADDR_W 32
`define LANE_SEL_W 4

// Descriptor packet count and engine index widths
`define LANE_COUNT_W 16
`define LANE_ENGINE_ID_W 2

// Default wait limits in cycles, for one handshake and for a whole run
`define LANE_STEP_TIMEOUT 200
`define LANE_RUN_TIMEOUT 20000

`endif

// File: src/lane_pkg.sv
// ----------------------------------------------------------
// Shared types of the graph lane
// Opcodes, engine states and the packed structs that carry
// the descriptor, the lane stream and the memory traffic
// ----------------------------------------------------------
`default_nettype none

`include "lane_cfg.svh"

package lane_pkg;

    // Combine operation applied by every engine
    typedef enum logic [1:0] {
        LANE_OP_PASS = 2'd0,
        LANE_OP_ADD  = 2'd1,
        LANE_OP_XOR  = 2'd2,
        LANE_OP_MAX  = 2'd3
    } lane_op_e;

    // Per-engine packet FSM
    typedef enum logic [1:0] {
        ENGINE_IDLE = 2'd0,
        ENGINE_READ = 2'd1,
        ENGINE_WAIT = 2'd2,
        ENGINE_SEND = 2'd3
    } engine_state_e;

    // Kernel setup, one-cycle valid pulse
    typedef struct packed {
        logic                      valid;
        logic [`LANE_ADDR_W-1:0]   base_address;
        lane_op_e                  opcode;
        logic [`LANE_COUNT_W-1:0]  packet_count;
    } kernel_descriptor_t;

    // Lane stream payload, ready travels on its own wire
    typedef struct packed {
        logic                    valid;
        logic [`LANE_KEY_W-1:0]  key;
        logic [`LANE_DATA_W-1:0] value;
    } engine_packet_t;

    // Engine read request, held until its response
    typedef struct packed {
        logic                    valid;
        logic [`LANE_ADDR_W-1:0] address;
    } memory_request_t;

    // Read data steered back to one engine
    typedef struct packed {
        logic                    valid;
        logic [`LANE_DATA_W-1:0] data;
    } memory_response_t;

endpackage : lane_pkg

`default_nettype wire

// File: src/lane_engine.sv
// ----------------------------------------------------------
// One graph engine of the lane
// Takes a packet, reads the word at base + key + ENGINE_ID,
// folds it into the value with the descriptor opcode and
// hands the packet on. Holds a single packet at a time
// ----------------------------------------------------------
`default_nettype none

`include "lane_cfg.svh"

module lane_engine #(
    parameter logic [`LANE_ENGINE_ID_W-1:0] ENGINE_ID = '0
) (
    input  logic                         ap_clk,
    input  logic                         areset_lane_template,
    input  lane_pkg::kernel_descriptor_t descriptor_i,
    input  lane_pkg::engine_packet_t     packet_i,
    output logic                         packet_ready_o,
    output lane_pkg::engine_packet_t     packet_o,
    input  logic                         packet_ready_i,
    output lane_pkg::memory_request_t    mem_request_o,
    input  lane_pkg::memory_response_t   mem_response_i,
    output logic                         idle_o
);

    localparam int KEY_W  = `LANE_KEY_W;
    localparam int DATA_W = `LANE_DATA_W;
    localparam int ADDR_W = `LANE_ADDR_W;

    // ----------------------------------------------------------
    // State and registers
    // ----------------------------------------------------------
    lane_pkg::engine_state_e state_q;

    // Kernel setup, loaded from the broadcast descriptor
    lane_pkg::lane_op_e      op_q;
    logic [ADDR_W-1:0]       base_q;

    // Packet in flight and its read address
    logic [KEY_W-1:0]        key_q;
    logic [DATA_W-1:0]       value_q;
    logic [ADDR_W-1:0]       addr_q;

    logic                    take;
    logic                    reading;
    logic                    rsp_hit;

    // Combine step, add and xor wrap at DATA_W, max is unsigned
    function automatic logic [DATA_W-1:0] fold_word(
        input lane_pkg::lane_op_e op,
        input logic [DATA_W-1:0]  acc,
        input logic [DATA_W-1:0]  word
    );
        case (op)
            lane_pkg::LANE_OP_ADD: fold_word = acc + word;
            lane_pkg::LANE_OP_XOR: fold_word = acc ^ word;
            lane_pkg::LANE_OP_MAX: fold_word = (word > acc) ? word : acc;
            default:               fold_word = acc;
        endcase
    endfunction

    // Accept only from IDLE
    assign take    = packet_i.valid & packet_ready_o;
    // Request stays up through READ and WAIT
    assign reading = (state_q == lane_pkg::ENGINE_READ) | (state_q == lane_pkg::ENGINE_WAIT);
    assign rsp_hit = reading & mem_response_i.valid;

    // ----------------------------------------------------------
    // Descriptor latch
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (descriptor_i.valid) begin
            op_q   <= descriptor_i.opcode;
            base_q <= descriptor_i.base_address;
        end
    end

    // ----------------------------------------------------------
    // Packet FSM
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            state_q <= lane_pkg::ENGINE_IDLE;
        end else begin
            case (state_q)
                lane_pkg::ENGINE_IDLE: begin
                    // Pass skips memory, result is ready next cycle
                    if (take) begin
                        if (op_q == lane_pkg::LANE_OP_PASS) begin
                            state_q <= lane_pkg::ENGINE_SEND;
                        end else begin
                            state_q <= lane_pkg::ENGINE_READ;
                        end
                    end
                end
                lane_pkg::ENGINE_READ, lane_pkg::ENGINE_WAIT: begin
                    if (mem_response_i.valid) begin
                        state_q <= lane_pkg::ENGINE_SEND;
                    end else begin
                        state_q <= lane_pkg::ENGINE_WAIT;
                    end
                end
                lane_pkg::ENGINE_SEND: begin
                    // Hold the packet until downstream takes it
                    if (packet_ready_i) begin
                        state_q <= lane_pkg::ENGINE_IDLE;
                    end
                end
                default: state_q <= lane_pkg::ENGINE_IDLE;
            endcase
        end
    end

    // Payload capture and fold
    always_ff @(posedge ap_clk) begin
        if (take) begin
            key_q   <= packet_i.key;
            value_q <= packet_i.value;
            addr_q  <= base_q + ADDR_W'(packet_i.key) + ADDR_W'(ENGINE_ID);
        end else if (rsp_hit) begin
            value_q <= fold_word(op_q, value_q, mem_response_i.data);
        end
    end

    // ----------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------
    assign packet_ready_o = (state_q == lane_pkg::ENGINE_IDLE);
    assign idle_o         = (state_q == lane_pkg::ENGINE_IDLE);

    always_comb begin
        packet_o.valid        = (state_q == lane_pkg::ENGINE_SEND);
        packet_o.key          = key_q;
        packet_o.value        = value_q;
        mem_request_o.valid   = reading;
        mem_request_o.address = addr_q;
    end

endmodule : lane_engine

`default_nettype wire

// File: src/lane_memory_arbiter.sv
// ----------------------------------------------------------
// Memory arbiter of the lane
// Round-robin N-to-1 over the engine read requests onto a
// Wishbone classic master, one read per opened cycle
// Read data is steered back to the granted engine only
// ----------------------------------------------------------
`default_nettype none

`include "lane_cfg.svh"

module lane_memory_arbiter #(
    parameter int NUM_REQUESTORS = `LANE_NUM_ENGINES
) (
    input  logic                       ap_clk,
    input  logic                       areset_lane_template,
    input  lane_pkg::memory_request_t  request_i [NUM_REQUESTORS],
    output lane_pkg::memory_response_t response_o [NUM_REQUESTORS],
    output logic                       wb_cyc_o,
    output logic                       wb_stb_o,
    output logic                       wb_we_o,
    output logic [`LANE_ADDR_W-1:0]    wb_adr_o,
    output logic [`LANE_SEL_W-1:0]     wb_sel_o,
    input  logic [`LANE_DATA_W-1:0]    wb_dat_i,
    input  logic                       wb_ack_i
);

    localparam int ADDR_W = `LANE_ADDR_W;
    localparam int IDX_W  = (NUM_REQUESTORS > 1) ? $clog2(NUM_REQUESTORS) : 1;

    // ----------------------------------------------------------
    // Grant state
    // ----------------------------------------------------------
    // Busy spans grant to ack
    logic              busy_q;
    // Granted index, doubles as the round-robin pointer
    logic [IDX_W-1:0]  grant_q;
    logic [ADDR_W-1:0] adr_q;

    logic              pick_valid;
    logic [IDX_W-1:0]  pick_idx;
    logic              done_xfer;

    assign done_xfer = busy_q & wb_ack_i;

    // Search starts one past the last grant
    always_comb begin
        int cand;
        pick_valid = 1'b0;
        pick_idx   = grant_q;
        for (int off = 1; off <= NUM_REQUESTORS; off++) begin
            cand = (int'(grant_q) + off) % NUM_REQUESTORS;
            if (!pick_valid && request_i[cand].valid) begin
                pick_valid = 1'b1;
                pick_idx   = IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            busy_q  <= 1'b0;
            // First search lands on requestor 0
            grant_q <= IDX_W'(NUM_REQUESTORS - 1);
        end else if (done_xfer) begin
            // Idle for one cycle, the served engine drops its request
            busy_q <= 1'b0;
        end else if (!busy_q && pick_valid) begin
            busy_q  <= 1'b1;
            grant_q <= pick_idx;
        end
    end

    // Address is captured with the grant and held to the ack
    always_ff @(posedge ap_clk) begin
        if (!busy_q && pick_valid) begin
            adr_q <= request_i[pick_idx].address;
        end
    end

    // ----------------------------------------------------------
    // Wishbone master, read only, full word
    // ----------------------------------------------------------
    assign wb_cyc_o = busy_q;
    assign wb_stb_o = busy_q;
    assign wb_we_o  = 1'b0;
    assign wb_adr_o = adr_q;
    assign wb_sel_o = '1;

    // ----------------------------------------------------------
    // Response steering, same cycle as the ack
    // ----------------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_REQUESTORS; i++) begin
            response_o[i].valid = done_xfer & (grant_q == IDX_W'(i));
            response_o[i].data  = wb_dat_i;
        end
    end

endmodule : lane_memory_arbiter

`default_nettype wire

// File: src/lane_template.sv
// ----------------------------------------------------------
// Top level of one graph lane
// Registers the descriptor, broadcasts it to the engine chain,
// links the engine streams in0 -> 0 -> 1 -> .. -> out and
// counts output packets. done_o marks the end of a kernel
// ----------------------------------------------------------
`default_nettype none

`include "lane_cfg.svh"

module lane_template (
    input  logic                         ap_clk,
    input  logic                         areset_lane_template,
    input  lane_pkg::kernel_descriptor_t descriptor_i,
    input  lane_pkg::engine_packet_t     lane_in_i,
    output logic                         lane_in_ready_o,
    output lane_pkg::engine_packet_t     lane_out_o,
    input  logic                         lane_out_ready_i,
    output logic                         wb_cyc_o,
    output logic                         wb_stb_o,
    output logic                         wb_we_o,
    output logic [`LANE_ADDR_W-1:0]      wb_adr_o,
    output logic [`LANE_SEL_W-1:0]       wb_sel_o,
    input  logic [`LANE_DATA_W-1:0]      wb_dat_i,
    input  logic                         wb_ack_i,
    output logic                         done_o
);

    localparam int NUM_ENGINES = `LANE_NUM_ENGINES;
    localparam int COUNT_W     = `LANE_COUNT_W;
    localparam int ENGINE_ID_W = `LANE_ENGINE_ID_W;

    // ----------------------------------------------------------
    // Wires and registers
    // ----------------------------------------------------------
    lane_pkg::kernel_descriptor_t desc_q;
    logic                         lane_active_q;
    logic [COUNT_W-1:0]           out_count_q;

    logic                         lane_idle;
    logic                         desc_take;
    logic                         out_fire;
    logic                         count_done;

    // Stream links, index i feeds engine i
    lane_pkg::engine_packet_t     link_pkt [NUM_ENGINES+1];
    logic [NUM_ENGINES:0]         link_rdy;
    logic [NUM_ENGINES-1:0]       eng_idle;

    lane_pkg::memory_request_t    eng_req [NUM_ENGINES];
    lane_pkg::memory_response_t   eng_rsp [NUM_ENGINES];

    // New kernel only with nothing in flight
    assign lane_idle  = ~lane_active_q & ~desc_q.valid & (&eng_idle);
    assign desc_take  = descriptor_i.valid & lane_idle;
    assign out_fire   = lane_out_o.valid & lane_out_ready_i;
    assign count_done = lane_active_q & (out_count_q == desc_q.packet_count) & (&eng_idle);

    // ----------------------------------------------------------
    // Descriptor register, engines load it one cycle later
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            desc_q.valid <= 1'b0;
        end else begin
            desc_q.valid <= desc_take;
        end
        if (desc_take) begin
            desc_q.base_address <= descriptor_i.base_address;
            desc_q.opcode       <= descriptor_i.opcode;
            desc_q.packet_count <= descriptor_i.packet_count;
        end
    end

    // ----------------------------------------------------------
    // Packet count and done
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            lane_active_q <= 1'b0;
            out_count_q   <= '0;
            done_o        <= 1'b0;
        end else if (desc_q.valid) begin
            // Engines are set up on this edge
            lane_active_q <= 1'b1;
            out_count_q   <= '0;
            done_o        <= 1'b0;
        end else begin
            if (out_fire) begin
                out_count_q <= out_count_q + 1'b1;
            end
            // done_o holds until the next descriptor
            if (count_done) begin
                lane_active_q <= 1'b0;
                done_o        <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Lane ends of the engine chain
    // ----------------------------------------------------------
    // Input is closed outside an active kernel
    always_comb begin
        link_pkt[0]       = lane_in_i;
        link_pkt[0].valid = lane_in_i.valid & lane_active_q;
    end

    assign lane_in_ready_o       = link_rdy[0] & lane_active_q;
    assign link_rdy[NUM_ENGINES] = lane_out_ready_i;
    assign lane_out_o            = link_pkt[NUM_ENGINES];

    // ----------------------------------------------------------
    // Engines
    // ----------------------------------------------------------
    for (genvar i = 0; i < NUM_ENGINES; i++) begin : engines
        lane_engine #(
            .ENGINE_ID(ENGINE_ID_W'(i))
        ) engine (
            .ap_clk              (ap_clk),
            .areset_lane_template(areset_lane_template),
            .descriptor_i        (desc_q),
            .packet_i            (link_pkt[i]),
            .packet_ready_o      (link_rdy[i]),
            .packet_o            (link_pkt[i+1]),
            .packet_ready_i      (link_rdy[i+1]),
            .mem_request_o       (eng_req[i]),
            .mem_response_i      (eng_rsp[i]),
            .idle_o              (eng_idle[i])
        );
    end

    // ----------------------------------------------------------
    // Memory arbitration onto the Wishbone port
    // ----------------------------------------------------------
    lane_memory_arbiter #(
        .NUM_REQUESTORS(NUM_ENGINES)
    ) arbiter0 (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .request_i           (eng_req),
        .response_o          (eng_rsp),
        .wb_cyc_o            (wb_cyc_o),
        .wb_stb_o            (wb_stb_o),
        .wb_we_o             (wb_we_o),
        .wb_adr_o            (wb_adr_o),
        .wb_sel_o            (wb_sel_o),
        .wb_dat_i            (wb_dat_i),
        .wb_ack_i            (wb_ack_i)
    );

endmodule : lane_template

`default_nettype wire

// File: tb/lane_template_chk.sv
// ----------------------------------------------------------
// Protocol assertions for the graph lane
// Bound into every lane_template instance to cover the
// Wishbone master port, the lane output and done_o
// ----------------------------------------------------------
`default_nettype none

`include "lane_cfg.svh"

module lane_template_chk (
    input logic                     ap_clk,
    input logic                     areset_lane_template,
    input logic                     wb_cyc_o,
    input logic                     wb_stb_o,
    input logic [`LANE_ADDR_W-1:0]  wb_adr_o,
    input logic                     wb_ack_i,
    input lane_pkg::engine_packet_t lane_out_o,
    input logic                     lane_out_ready_i,
    input logic                     done_o
);

    // Failed assertions so far
    int failures = 0;

    // Cycle and strobe stay up together until the slave acks
    assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        (wb_stb_o && !wb_ack_i) |=> (wb_cyc_o && wb_stb_o))
        else begin
            $error("wb_cyc_o or wb_stb_o dropped before the ack");
            failures++;
        end

    // Address held until the slave acks
    assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        (wb_stb_o && !wb_ack_i) |=> $stable(wb_adr_o))
        else begin
            $error("wb_adr_o changed before the ack");
            failures++;
        end

    // Stalled output keeps its packet
    assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        (lane_out_o.valid && !lane_out_ready_i) |=> (lane_out_o.valid && $stable(lane_out_o)))
        else begin
            $error("lane_out changed under back-pressure");
            failures++;
        end

    // Held reset keeps done_o low after its first edge
    assert property (@(posedge ap_clk)
        (areset_lane_template && $past(areset_lane_template)) |-> !done_o)
        else begin
            $error("done_o high during reset");
            failures++;
        end

endmodule : lane_template_chk

bind lane_template lane_template_chk chk0 (
    .ap_clk              (ap_clk),
    .areset_lane_template(areset_lane_template),
    .wb_cyc_o            (wb_cyc_o),
    .wb_stb_o            (wb_stb_o),
    .wb_adr_o            (wb_adr_o),
    .wb_ack_i            (wb_ack_i),
    .lane_out_o          (lane_out_o),
    .lane_out_ready_i    (lane_out_ready_i),
    .done_o              (done_o)
);

`default_nettype wire

// File: tb/lane_template_tb.sv
// ----------------------------------------------------------
// Testbench for the graph lane top level
// Wishbone slave model with random ack delay, kernel runs
// for every opcode, back-pressure and a second descriptor
// Results are compared against a reference model of the
// four engine steps
// ----------------------------------------------------------
`default_nettype none

`include "lane_cfg.svh"

module lane_template_tb;

    localparam int NUM_ENGINES  = `LANE_NUM_ENGINES;
    localparam int ADDR_W       = `LANE_ADDR_W;
    localparam int DATA_W       = `LANE_DATA_W;
    localparam int STEP_TIMEOUT = `LANE_STEP_TIMEOUT;
    localparam int RUN_TIMEOUT  = `LANE_RUN_TIMEOUT;

    logic                         ap_clk;
    logic                         areset_lane_template;
    lane_pkg::kernel_descriptor_t descriptor_i;
    lane_pkg::engine_packet_t     lane_in_i;
    logic                         lane_in_ready_o;
    lane_pkg::engine_packet_t     lane_out_o;
    logic                         lane_out_ready_i;
    logic                         wb_cyc_o;
    logic                         wb_stb_o;
    logic                         wb_we_o;
    logic [ADDR_W-1:0]            wb_adr_o;
    logic [`LANE_SEL_W-1:0]       wb_sel_o;
    logic [DATA_W-1:0]            wb_dat_i;
    logic                         wb_ack_i;
    logic                         done_o;

    // Scoreboard and run state
    lane_pkg::engine_packet_t     expected_q [$];
    int                           error_count;
    int                           check_count;
    int                           outputs_seen;
    // 0 always ready, 1 random ready, 2 held low
    int                           out_mode;
    bit                           kernel_loaded;
    string                        test_name;
    logic [DATA_W-1:0]            mem_salt;
    int                           ack_wait;
    bit                           slave_busy;

    lane_template dut0 (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .descriptor_i        (descriptor_i),
        .lane_in_i           (lane_in_i),
        .lane_in_ready_o     (lane_in_ready_o),
        .lane_out_o          (lane_out_o),
        .lane_out_ready_i    (lane_out_ready_i),
        .wb_cyc_o            (wb_cyc_o),
        .wb_stb_o            (wb_stb_o),
        .wb_we_o             (wb_we_o),
        .wb_adr_o            (wb_adr_o),
        .wb_sel_o            (wb_sel_o),
        .wb_dat_i            (wb_dat_i),
        .wb_ack_i            (wb_ack_i),
        .done_o              (done_o)
    );

    always #2 ap_clk = ~ap_clk;

    // ----------------------------------------------------------
    // Memory contents and reference model
    // ----------------------------------------------------------
    // Odd multiplier keeps every address bit in the word
    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        mem_word = (addr * 32'h9e37_79b1) ^ mem_salt;
    endfunction

    // Engine k reads base + key + k and folds it into the value
    function automatic lane_pkg::engine_packet_t expected_packet(
        input lane_pkg::lane_op_e     op,
        input logic [ADDR_W-1:0]      base,
        input lane_pkg::engine_packet_t pkt
    );
        logic [DATA_W-1:0] acc;
        logic [DATA_W-1:0] word;
        acc = pkt.value;
        for (int k = 0; k < NUM_ENGINES; k++) begin
            word = mem_word(base + ADDR_W'(pkt.key) + ADDR_W'(k));
            if (op == lane_pkg::LANE_OP_ADD) begin
                acc = acc + word;
            end else if (op == lane_pkg::LANE_OP_XOR) begin
                acc = acc ^ word;
            end else if (op == lane_pkg::LANE_OP_MAX && word > acc) begin
                acc = word;
            end
        end
        expected_packet       = pkt;
        expected_packet.value = acc;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        error_count++;
        $display("Error %s: %s expected %h, actual %h", test_name, what, exp_v, act_v);
    endtask

    // ----------------------------------------------------------
    // Wishbone slave that acks after 0 to 3 cycles
    // ----------------------------------------------------------
    always @(negedge ap_clk) begin
        if (areset_lane_template) begin
            wb_ack_i   = 1'b0;
            slave_busy = 1'b0;
            ack_wait   = 0;
        end else if (wb_ack_i) begin
            // Transfer closed on the last rising edge
            wb_ack_i = 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (wb_we_o) begin
                error_count++;
                $display("%s: write cycle seen on the read-only memory port", test_name);
            end
            // Every read is a full word
            if (wb_sel_o != {`LANE_SEL_W{1'b1}}) begin
                report_mismatch("wb_sel_o", 64'({`LANE_SEL_W{1'b1}}), 64'(wb_sel_o));
            end
            if (!slave_busy) begin
                slave_busy = 1'b1;
                ack_wait   = $urandom_range(0, 3);
            end
            if (ack_wait == 0) begin
                wb_ack_i   = 1'b1;
                wb_dat_i   = mem_word(wb_adr_o);
                slave_busy = 1'b0;
            end else begin
                ack_wait--;
            end
        end
    end

    // ----------------------------------------------------------
    // Output side that drives ready and compares each transfer
    // ----------------------------------------------------------
    always @(negedge ap_clk) begin : compare_output
        lane_pkg::engine_packet_t exp_pkt;
        if (areset_lane_template) begin
            lane_out_ready_i = 1'b0;
        end else begin
            case (out_mode)
                0:       lane_out_ready_i = 1'b1;
                1:       lane_out_ready_i = ($urandom_range(0, 3) != 0);
                default: lane_out_ready_i = 1'b0;
            endcase
            // Valid and ready are settled here and the transfer is on the next rising edge
            if (lane_out_o.valid && lane_out_ready_i) begin
                outputs_seen++;
                check_count++;
                if (expected_q.size() == 0) begin
                    error_count++;
                    $display("%s: lane_out transfer with no packet outstanding", test_name);
                end else begin
                    exp_pkt = expected_q.pop_front();
                    if ({lane_out_o.key, lane_out_o.value} != {exp_pkt.key, exp_pkt.value}) begin
                        report_mismatch("key/value", 64'({exp_pkt.key, exp_pkt.value}),
                                        64'({lane_out_o.key, lane_out_o.value}));
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Stimulus tasks start and end on a falling edge
    // ----------------------------------------------------------
    // Mode and output count change away from the falling edge
    task automatic prepare_output_side(input int mode);
        @(posedge ap_clk);
        out_mode     = mode;
        outputs_seen = 0;
        @(negedge ap_clk);
    endtask

    task automatic load_descriptor(input lane_pkg::lane_op_e op, input logic [ADDR_W-1:0] base,
                                   input int count);
        int waited;
        if (kernel_loaded && !done_o) begin
            report_mismatch("done_o before descriptor", 64'd1, 64'(done_o));
        end
        descriptor_i.valid        = 1'b1;
        descriptor_i.base_address = base;
        descriptor_i.opcode       = op;
        descriptor_i.packet_count = count[`LANE_COUNT_W-1:0];
        @(negedge ap_clk);
        descriptor_i.valid = 1'b0;
        waited = 0;
        while (done_o && waited < STEP_TIMEOUT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (done_o) begin
            error_count++;
            $display("%s: done_o did not drop after the new descriptor", test_name);
        end
        kernel_loaded = 1'b1;
    endtask

    task automatic send_packet(input lane_pkg::lane_op_e op, input logic [ADDR_W-1:0] base);
        lane_pkg::engine_packet_t pkt;
        int waited;
        pkt.valid = 1'b1;
        pkt.key   = $urandom_range(0, 16'hffff);
        pkt.value = $urandom();
        expected_q.push_back(expected_packet(op, base, pkt));
        lane_in_i = pkt;
        waited = 0;
        while (!lane_in_ready_o && waited < STEP_TIMEOUT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (!lane_in_ready_o) begin
            error_count++;
            $display("%s: lane_in_ready_o stayed low, packet not taken", test_name);
        end
        @(negedge ap_clk);
        lane_in_i.valid = 1'b0;
    endtask

    task automatic wait_done(input int count);
        int waited;
        waited = 0;
        while (!done_o && waited < RUN_TIMEOUT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (!done_o) begin
            error_count++;
            $display("%s: done_o did not rise within %0d cycles", test_name, RUN_TIMEOUT);
        end else begin
            if (outputs_seen != count) begin
                report_mismatch("output count", 64'(count), 64'(outputs_seen));
            end
            if (expected_q.size() != 0) begin
                report_mismatch("packets left", 64'd0, 64'(expected_q.size()));
            end
        end
    endtask

    // One kernel that may first fill the lane with lane_out held low
    task automatic run_kernel(input string name, input lane_pkg::lane_op_e op,
                              input logic [ADDR_W-1:0] base, input int count,
                              input int mode, input bit stall);
        int sent;
        int waited;
        int low_run;
        test_name = name;
        sent = 0;
        prepare_output_side(stall ? 2 : mode);
        load_descriptor(op, base, count);
        if (stall) begin
            while (sent < NUM_ENGINES) begin
                send_packet(op, base);
                sent++;
            end
            // Full chain keeps the input closed and a packet waiting at the output
            waited  = 0;
            low_run = 0;
            while ((low_run < 16 || !lane_out_o.valid) && waited < STEP_TIMEOUT) begin
                @(negedge ap_clk);
                waited++;
                low_run = lane_in_ready_o ? 0 : low_run + 1;
            end
            if (low_run < 16) begin
                error_count++;
                $display("%s: lane_in_ready_o did not fall while lane_out was stalled", name);
            end
            if (!lane_out_o.valid) begin
                report_mismatch("lane_out valid while stalled", 64'd1, 64'(lane_out_o.valid));
            end
            prepare_output_side(mode);
        end
        while (sent < count) begin
            send_packet(op, base);
            sent++;
            if (mode != 0) begin
                repeat ($urandom_range(0, 2)) @(negedge ap_clk);
            end
        end
        wait_done(count);
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        ap_clk               = 1'b0;
        areset_lane_template = 1'b1;
        descriptor_i         = '0;
        lane_in_i            = '0;
        lane_out_ready_i     = 1'b0;
        wb_dat_i             = '0;
        wb_ack_i             = 1'b0;
        error_count          = 0;
        check_count          = 0;
        outputs_seen         = 0;
        out_mode             = 0;
        kernel_loaded        = 1'b0;
        test_name            = "reset";
        void'($urandom(32'hd5bf8451));
        mem_salt = $urandom();
        repeat (8) @(negedge ap_clk);
        areset_lane_template = 1'b0;
        @(negedge ap_clk);
        // Quiet outputs and a closed input before any descriptor
        if ({lane_out_o.valid, wb_cyc_o, wb_stb_o, done_o, lane_in_ready_o} != 5'b0) begin
            report_mismatch("idle outputs", 64'd0,
                            64'({lane_out_o.valid, wb_cyc_o, wb_stb_o, done_o, lane_in_ready_o}));
        end
        run_kernel("pass", lane_pkg::LANE_OP_PASS, 32'h0000_1000, 20, 0, 1'b0);
        run_kernel("add", lane_pkg::LANE_OP_ADD, $urandom(), 16, 0, 1'b0);
        run_kernel("xor", lane_pkg::LANE_OP_XOR, $urandom(), 12, 1, 1'b0);
        run_kernel("max", lane_pkg::LANE_OP_MAX, $urandom(), 12, 1, 1'b0);
        run_kernel("stall", lane_pkg::LANE_OP_ADD, $urandom(), 20, 1, 1'b1);
        run_kernel("second", lane_pkg::LANE_OP_MAX, 32'h00ab_0000, 9, 1, 1'b0);
        error_count += dut0.chk0.failures;
        $display("Checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : lane_template_tb

`default_nettype wire

// File: filelist.f
+incdir+src
src/lane_pkg.sv
src/lane_engine.sv
src/lane_memory_arbiter.sv
src/lane_template.sv
tb/lane_template_chk.sv
tb/lane_template_tb.sv

// File: Bender.yml
package:
  name: lane_template

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/lane_pkg.sv
      - src/lane_engine.sv
      - src/lane_memory_arbiter.sv
      - src/lane_template.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/lane_template_chk.sv
      - tb/lane_template_tb.sv
